// ==== filelist.f ====
+incdir+hw
hw/npmPkg.sv
hw/npmDispatcher.sv
hw/npmPiReset.sv
hw/npmPoReset.sv
hw/npmPhyInitTop.sv
verif/npmPhyInitChecker.sv
verif/npmPhyInitTb.sv

// ==== hw/npmDispatcher.sv ====
`timescale 1ns/1ps

module npmDispatcher (
    input  logic            iSystemClock,
    input  logic            iReset,
    input  npmPkg::npmCmd_t iCmd,
    input  logic            iPiReady,
    input  logic            iPiLastStep,
    input  logic            iPoReady,
    input  logic            iPoLastStep,
    output logic            oPiStart,
    output logic            oPoStart,
    output logic            oReady,
    output logic            oLastStep,
    output logic            oCmdError
);
    import npmPkg::*;

    logic piActive;  // PI primitive owns the merged status
    logic poActive;
    logic isPi;
    logic isPo;
    logic isNop;
    logic isIllegal;
    logic accept;

    assign isPi      = (iCmd.opcode == PI_RESET);
    assign isPo      = (iCmd.opcode == PO_RESET);
    assign isNop     = (iCmd.opcode == NOP);
    assign isIllegal = !(isPi || isPo || isNop);

    // Merged status follows only the active primitive
    always_comb begin
        if (piActive) begin
            oReady    = iPiReady;
            oLastStep = iPiLastStep;
        end else if (poActive) begin
            oReady    = iPoReady;
            oLastStep = iPoLastStep;
        end else begin
            oReady    = iPiReady & iPoReady;  // Idle, both parked in Ready
            oLastStep = 1'b0;
        end
    end

    assign accept   = iCmd.start & oReady;
    assign oPiStart = accept & isPi;
    assign oPoStart = accept & isPo;

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            piActive  <= 1'b0;
            poActive  <= 1'b0;
            oCmdError <= 1'b0;
        end else begin
            oCmdError <= accept & isIllegal;
            if (oPiStart) begin
                piActive <= 1'b1;
                poActive <= 1'b0;
            end else if (oPoStart) begin
                piActive <= 1'b0;
                poActive <= 1'b1;
            end else if (oLastStep) begin
                // Run ended without a restart
                piActive <= 1'b0;
                poActive <= 1'b0;
            end
        end
    end

endmodule

// ==== hw/npmPhyInitTop.sv ====
`timescale 1ns/1ps

module npmPhyInitTop (
    input  logic               iSystemClock,
    input  logic               iReset,
    input  npmPkg::npmCmd_t    iCmd,
    output logic               oReady,
    output logic               oLastStep,
    output logic               oCmdError,
    output npmPkg::npmPhyCtl_t oPhyCtl
);

    logic piStart;
    logic piReady;
    logic piLastStep;
    logic piReset;
    logic poStart;
    logic poReady;
    logic poLastStep;
    logic poReset;

    npmDispatcher u_npmDispatcher (
        .iSystemClock (iSystemClock),
        .iReset       (iReset),
        .iCmd         (iCmd),
        .iPiReady     (piReady),
        .iPiLastStep  (piLastStep),
        .iPoReady     (poReady),
        .iPoLastStep  (poLastStep),
        .oPiStart     (piStart),
        .oPoStart     (poStart),
        .oReady       (oReady),
        .oLastStep    (oLastStep),
        .oCmdError    (oCmdError)
    );

    npmPiReset u_npmPiReset (
        .iSystemClock (iSystemClock),
        .iReset       (iReset),
        .iStart       (piStart),
        .oReady       (piReady),
        .oLastStep    (piLastStep),
        .oPiReset     (piReset)
    );

    npmPoReset u_npmPoReset (
        .iSystemClock (iSystemClock),
        .iReset       (iReset),
        .iStart       (poStart),
        .oReady       (poReady),
        .oLastStep    (poLastStep),
        .oPoReset     (poReset)
    );

    assign oPhyCtl.piReset = piReset;  // PHY-facing reset levels
    assign oPhyCtl.poReset = poReset;

endmodule

// ==== hw/npmPiReset.sv ====
`timescale 1ns/1ps
`include "npm_defs.svh"

module npmPiReset (
    input  logic iSystemClock,
    input  logic iReset,
    input  logic iStart,
    output logic oReady,
    output logic oLastStep,
    output logic oPiReset
);
    import npmPkg::*;

    localparam logic [`NPM_TIMER_W-1:0] holdLast   = `NPM_TIMER_W'(`NPM_PI_HOLD - 1);
    localparam logic [`NPM_TIMER_W-1:0] settleLast = `NPM_TIMER_W'(`NPM_PI_SETTLE - 1);

    npmPirState_t             curState;
    npmPirState_t             nxtState;
    logic                     readyReg;
    logic                     resetReg;
    logic [`NPM_TIMER_W-1:0]  timer;
    logic                     resetDone;
    logic                     jobDone;

    assign resetDone = (curState == PirResetLoop) && (timer == holdLast);
    assign jobDone   = (curState == PirReadyLoop) && (timer == settleLast);

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            curState <= PirReset;
        end else begin
            curState <= nxtState;
        end
    end

    always_comb begin
        case (curState)
            PirReset: begin
                nxtState = PirReady;
            end
            PirReady: begin
                nxtState = iStart ? PirResetFirst : PirReady;
            end
            PirResetFirst: begin
                nxtState = PirResetLoop;
            end
            PirResetLoop: begin
                nxtState = resetDone ? PirReadyFirst : PirResetLoop;
            end
            PirReadyFirst: begin
                nxtState = PirReadyLoop;
            end
            PirReadyLoop: begin
                // Held start chains straight into the next pulse
                if (jobDone) begin
                    nxtState = iStart ? PirResetFirst : PirReady;
                end else begin
                    nxtState = PirReadyLoop;
                end
            end
            default: begin
                nxtState = PirReady;
            end
        endcase
    end

    // Outputs decoded from the next state
    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            readyReg <= 1'b0;
            timer    <= '0;
            resetReg <= 1'b0;
        end else begin
            case (nxtState)
                PirReady: begin
                    readyReg <= 1'b1;
                    timer    <= '0;
                    resetReg <= 1'b0;
                end
                PirResetFirst: begin
                    readyReg <= 1'b0;
                    timer    <= '0;
                    resetReg <= 1'b1;  // Pulse starts
                end
                PirResetLoop: begin
                    readyReg <= 1'b0;
                    timer    <= timer + 1'b1;
                    resetReg <= 1'b1;
                end
                PirReadyFirst: begin
                    readyReg <= 1'b0;
                    timer    <= '0;
                    resetReg <= 1'b0;  // Settle window starts
                end
                PirReadyLoop: begin
                    readyReg <= 1'b0;
                    timer    <= timer + 1'b1;
                    resetReg <= 1'b0;
                end
                default: begin
                    readyReg <= 1'b0;
                    timer    <= '0;
                    resetReg <= 1'b0;
                end
            endcase
        end
    end

    assign oReady    = readyReg | jobDone;  // Ready already in last step
    assign oLastStep = jobDone;
    assign oPiReset  = resetReg;

endmodule

// ==== hw/npmPkg.sv ====
package npmPkg;

    // Command opcodes, every other code is illegal
    typedef enum logic [2:0] {
        NOP      = 3'd0,
        PI_RESET = 3'd1,
        PO_RESET = 3'd2
    } npmOpcode_t;

    typedef struct packed {
        logic       start;  // Level, taken while ready
        npmOpcode_t opcode;
    } npmCmd_t;

    typedef struct packed {
        logic piReset;  // Input-delay reset level
        logic poReset;  // Output-path reset level
    } npmPhyCtl_t;

    typedef enum logic [5:0] {
        PirReset      = 6'b00_0001,
        PirReady      = 6'b00_0010,
        PirResetFirst = 6'b00_0100,
        PirResetLoop  = 6'b00_1000,
        PirReadyFirst = 6'b01_0000,
        PirReadyLoop  = 6'b10_0000
    } npmPirState_t;

    typedef enum logic [5:0] {
        PorReset      = 6'b00_0001,
        PorReady      = 6'b00_0010,
        PorResetFirst = 6'b00_0100,
        PorResetLoop  = 6'b00_1000,
        PorReadyFirst = 6'b01_0000,
        PorReadyLoop  = 6'b10_0000
    } npmPorState_t;

endpackage

// ==== hw/npmPoReset.sv ====
`timescale 1ns/1ps
`include "npm_defs.svh"

module npmPoReset (
    input  logic iSystemClock,
    input  logic iReset,
    input  logic iStart,
    output logic oReady,
    output logic oLastStep,
    output logic oPoReset
);
    import npmPkg::*;

    localparam logic [`NPM_TIMER_W-1:0] holdLast   = `NPM_TIMER_W'(`NPM_PO_HOLD - 1);
    localparam logic [`NPM_TIMER_W-1:0] settleLast = `NPM_TIMER_W'(`NPM_PO_SETTLE - 1);

    npmPorState_t             curState;
    npmPorState_t             nxtState;
    logic                     readyReg;
    logic                     resetReg;
    logic [`NPM_TIMER_W-1:0]  timer;
    logic                     resetDone;
    logic                     jobDone;

    assign resetDone = (curState == PorResetLoop) && (timer == holdLast);
    assign jobDone   = (curState == PorReadyLoop) && (timer == settleLast);

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            curState <= PorReset;
        end else begin
            curState <= nxtState;
        end
    end

    always_comb begin
        case (curState)
            PorReset: begin
                nxtState = PorReady;
            end
            PorReady: begin
                nxtState = iStart ? PorResetFirst : PorReady;
            end
            PorResetFirst: begin
                nxtState = PorResetLoop;
            end
            PorResetLoop: begin
                nxtState = resetDone ? PorReadyFirst : PorResetLoop;
            end
            PorReadyFirst: begin
                nxtState = PorReadyLoop;
            end
            PorReadyLoop: begin
                if (jobDone) begin
                    nxtState = iStart ? PorResetFirst : PorReady;  // Restart or idle
                end else begin
                    nxtState = PorReadyLoop;
                end
            end
            default: begin
                nxtState = PorReady;
            end
        endcase
    end

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            readyReg <= 1'b0;
            timer    <= '0;
            resetReg <= 1'b0;
        end else begin
            case (nxtState)
                PorReady: begin
                    readyReg <= 1'b1;
                    timer    <= '0;
                    resetReg <= 1'b0;
                end
                PorResetFirst: begin
                    readyReg <= 1'b0;
                    timer    <= '0;
                    resetReg <= 1'b1;
                end
                PorResetLoop: begin
                    readyReg <= 1'b0;
                    timer    <= timer + 1'b1;  // Hold count
                    resetReg <= 1'b1;
                end
                PorReadyFirst: begin
                    readyReg <= 1'b0;
                    timer    <= '0;
                    resetReg <= 1'b0;
                end
                PorReadyLoop: begin
                    readyReg <= 1'b0;
                    timer    <= timer + 1'b1;  // Settle count
                    resetReg <= 1'b0;
                end
                default: begin
                    readyReg <= 1'b0;
                    timer    <= '0;
                    resetReg <= 1'b0;
                end
            endcase
        end
    end

    assign oReady    = readyReg | jobDone;
    assign oLastStep = jobDone;
    assign oPoReset  = resetReg;

endmodule

// ==== hw/npm_defs.svh ====
`ifndef NPM_DEFS_SVH
`define NPM_DEFS_SVH

// Width of the hold/settle timers in both primitives
`define NPM_TIMER_W 10

// Input path: cycles with reset high, then cycles up to and including last step
`define NPM_PI_HOLD 10
`define NPM_PI_SETTLE 400

// Output path counts
`define NPM_PO_HOLD 6
`define NPM_PO_SETTLE 200

`endif

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module npmPhyInitTb -f filelist.f \
        -o npmPhyInitSim; then
    echo "Verilator build failed"
    exit 1
fi

if ! output=$(./obj_dir/npmPhyInitSim); then
    echo "$output"
    echo "Simulation exited with an error"
    exit 1
fi
echo "$output"

if echo "$output" | grep -qx "Test OK"; then
    exit 0
fi
exit 1

// ==== verif/npmPhyInitChecker.sv ====
`timescale 1ns/1ps
`include "npm_defs.svh"

module npmPhyInitChecker (
    input  logic               iSystemClock,
    input  logic               iReset,
    input  npmPkg::npmCmd_t    cmd,
    input  logic               ready,
    input  logic               lastStep,
    input  logic               cmdError,
    input  npmPkg::npmPhyCtl_t phyCtl,
    output int                 errors,
    output int                 runs,
    output int                 lastSteps
);
    import npmPkg::*;

    typedef struct packed {
        int hold;
        int settle;
    } npmTiming_t;

    // Expected pulse hold and settle window of a reset opcode
    function automatic npmTiming_t expectedTiming(input npmOpcode_t op);
        npmTiming_t timing;
        if (op == PO_RESET) begin
            timing.hold   = `NPM_PO_HOLD;
            timing.settle = `NPM_PO_SETTLE;
        end else begin
            timing.hold   = `NPM_PI_HOLD;
            timing.settle = `NPM_PI_SETTLE;
        end
        return timing;
    endfunction

    task automatic compare(input string what, input logic got, input logic expected);
        if (got !== expected) begin
            errors++;
            $display("Fail at %0t ns: %s expected %b, got %b", $time, what, expected, got);
        end
    endtask

    // Cycle model, sampled mid-cycle where inputs and outputs are settled
    initial begin
        npmOpcode_t activeOp;  // NOP while no run is expected
        npmTiming_t timing;
        int         step;      // Cycles since the accepting edge
        logic       started;
        logic       errorDue;
        logic       resetSeen;
        logic       expHold;
        logic       expLast;
        logic       expReady;
        errors    = 0;
        runs      = 0;
        lastSteps = 0;
        activeOp  = NOP;
        step      = 0;
        started   = 1'b0;
        errorDue  = 1'b0;
        resetSeen = 1'b0;
        forever begin
            @(negedge iSystemClock);
            timing   = expectedTiming(activeOp);
            expHold  = !iReset && (activeOp != NOP) && (step <= timing.hold);
            expLast  = !iReset && (activeOp != NOP) && (step == timing.hold + timing.settle);
            expReady = expLast || (!iReset && started && (activeOp == NOP));
            compare("piReset", phyCtl.piReset, expHold && (activeOp == PI_RESET));
            compare("poReset", phyCtl.poReset, expHold && (activeOp == PO_RESET));
            compare("oReady", ready, expReady);
            compare("oLastStep", lastStep, expLast);
            compare("oCmdError", cmdError, errorDue);
            if ((phyCtl.piReset || phyCtl.poReset) && !resetSeen) begin
                runs++;  // Measured pulse start
            end
            if (lastStep) begin
                lastSteps++;
            end
            resetSeen = phyCtl.piReset || phyCtl.poReset;
            errorDue  = 1'b0;
            step++;
            if (expLast) begin
                activeOp = NOP;  // Unless start restarts it below
            end
            if (iReset) begin
                activeOp = NOP;
            end else if (cmd.start && expReady) begin
                if (cmd.opcode == PI_RESET || cmd.opcode == PO_RESET) begin
                    activeOp = cmd.opcode;
                    step     = 1;
                end else if (cmd.opcode != NOP) begin
                    errorDue = 1'b1;
                end
            end
            started = !iReset;
        end
    end

endmodule

// ==== verif/npmPhyInitTb.sv ====
`timescale 1ns/1ps
`include "npm_defs.svh"

module npmPhyInitTb;
    import npmPkg::*;

    localparam int piRun      = `NPM_PI_HOLD + `NPM_PI_SETTLE;
    localparam int poRun      = `NPM_PO_HOLD + `NPM_PO_SETTLE;
    localparam int randomRuns = 12;
    // Longest run of every test plus idle gaps
    localparam int watchdogCycles = 4 * piRun + 2 * poRun + randomRuns * (piRun + 8) + 400;

    logic        iSystemClock;
    logic        iReset;
    npmCmd_t     iCmd;
    logic        oReady;
    logic        oLastStep;
    logic        oCmdError;
    npmPhyCtl_t  oPhyCtl;
    int          errors;
    int          runs;
    int          lastSteps;
    int          tbErrors;
    int          errorsBefore;
    int          testCount;
    int unsigned lcgState;

    npmPhyInitTop u_npmPhyInitTop (.*);

    npmPhyInitChecker u_npmPhyInitChecker (
        .iSystemClock (iSystemClock),
        .iReset       (iReset),
        .cmd          (iCmd),
        .ready        (oReady),
        .lastStep     (oLastStep),
        .cmdError     (oCmdError),
        .phyCtl       (oPhyCtl),
        .errors       (errors),
        .runs         (runs),
        .lastSteps    (lastSteps)
    );

    initial begin
        iSystemClock = 1'b0;
        forever #50 iSystemClock = ~iSystemClock;
    end

    initial begin
        repeat (watchdogCycles) @(posedge iSystemClock);
        $display("Timeout: the tests did not end within %0d clock cycles", watchdogCycles);
        $display("Test FAILED");
        $finish;
    end

    function automatic int unsigned nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState >> 8;
    endfunction

    task automatic tick(input int cycles);
        repeat (cycles) @(posedge iSystemClock);
        #1;  // Drive point just after the edge
    endtask

    task automatic issue(input npmOpcode_t op, input int cycles);
        iCmd = '{start: 1'b1, opcode: op};
        tick(cycles);
        iCmd = '0;
    endtask

    // Wait for the last-step pulse, return at the next drive point
    task automatic waitDone();
        @(negedge iSystemClock);
        while (!oLastStep) begin
            @(negedge iSystemClock);
        end
        tick(1);
    endtask

    task automatic endTest(input string name);
        testCount++;
        $display("%s: %0d errors", name, errors + tbErrors - errorsBefore);
        errorsBefore = errors + tbErrors;
    endtask

    initial begin
        int          runsBefore;
        int unsigned draw;
        npmOpcode_t  op;
        iReset       = 1'b1;
        iCmd         = '0;
        lcgState     = 83;
        tbErrors     = 0;
        errorsBefore = 0;
        testCount    = 0;
        tick(5);
        iReset = 1'b0;
        tick(3);
        endTest("Reset");

        issue(PI_RESET, 1);
        waitDone();
        tick(2);
        endTest("PI reset");

        issue(PO_RESET, 1);
        waitDone();
        tick(2);
        endTest("PO reset");

        runsBefore = runs;
        iCmd       = '{start: 1'b1, opcode: PI_RESET};  // Held through two last steps
        waitDone();
        waitDone();
        iCmd = '0;
        waitDone();
        tick(2);
        if ((runs - runsBefore != 3) || (lastSteps != runs)) begin
            tbErrors++;
            $display("Fail at %0t ns: %0d runs against %0d last steps after chaining",
                     $time, runs, lastSteps);
        end
        endTest("Chaining");

        issue(npmOpcode_t'(3'd5), 1);
        tick(2);
        issue(NOP, 2);
        tick(2);
        issue(PO_RESET, 1);
        tick(3);
        issue(PI_RESET, 4);  // Busy, ignored
        issue(npmOpcode_t'(3'd7), 2);
        waitDone();
        tick(2);
        endTest("Ignored and illegal commands");

        for (int i = 0; i < randomRuns; i++) begin
            draw = nextRandom();
            case (draw % 4)
                0: op = NOP;
                1: op = PI_RESET;
                2: op = PO_RESET;
                default: op = npmOpcode_t'(3'(3 + (draw >> 4) % 5));
            endcase
            tick(int'(1 + (draw >> 8) % 4));
            issue(op, 1);
            if (op == PI_RESET || op == PO_RESET) begin
                waitDone();
            end
        end
        tick(2);
        endTest("Random sequence");

        $display("%0d tests run, %0d errors", testCount, errors + tbErrors);
        if (errors + tbErrors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
